/* trap_check_top.f */
+incdir+rtl
rtl/trap_check_pkg.sv
rtl/trap_check_cfg.sv
rtl/expected_pc_log.sv
rtl/actual_mepc_log.sv
rtl/mepc_compare.sv
rtl/trap_check_top.sv
testbench/trap_check_checker.sv
testbench/tb_trap_check.sv

/* Makefile */
# Verilator build and run of the trap check testbench

OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run and look for the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
	  --top-module tb_trap_check -Mdir $(OBJ_DIR) -f trap_check_top.f
	./$(OBJ_DIR)/Vtb_trap_check | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_trap_check.sv */
////////////////////
// Trap check testbench
// Random exception streams checked against a cycle model of the logs
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "trap_check_consts.svh"

module tb_trap_check;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 4;
  localparam int STREAM_LEN   = 40;
  // Three random streams plus a fixed overhead of about 30 cycles per test
  localparam int TEST_CYCLES  = RESET_CYCLES + 3 * STREAM_LEN + 5 * 30;
  localparam int TIMEOUT_NS   = (TEST_CYCLES + 100) * CLK_PERIOD;

  logic clk, rst_ni;
  logic wb_valid, wb_mpu_err, wb_bus_err, wb_illegal, wb_ecall, wb_ebreak;
  logic irq_ack, debug_pending, debug_allowed, nmi_taken, debug_mode;
  logic save_cause, cause_irq, cfg_we;
  trap_check_pkg::pc_t         wb_pc, mepc_next;
  trap_check_pkg::cause_code_t cause_code;
  trap_check_pkg::cfg_addr_t   cfg_addr;
  trap_check_pkg::class_vec_t  cfg_wdata, match, mismatch, found_exp, found_act;
  int errors = 0;

  // Reference model state
  logic                       m_clear;
  trap_check_pkg::class_vec_t m_en, m_found_exp, m_found_act, m_match, m_mismatch;
  trap_check_pkg::pc_t        m_exp_pc [`TC_NUM_CLASS];
  trap_check_pkg::pc_t        m_act_pc [`TC_NUM_CLASS];

  trap_check_top u_dut (
    .clk(clk), .rst_ni(rst_ni),
    .wb_valid_i(wb_valid), .wb_pc_i(wb_pc),
    .wb_mpu_err_i(wb_mpu_err), .wb_bus_err_i(wb_bus_err), .wb_illegal_i(wb_illegal),
    .wb_ecall_i(wb_ecall), .wb_ebreak_i(wb_ebreak),
    .irq_ack_i(irq_ack), .debug_pending_i(debug_pending), .debug_allowed_i(debug_allowed),
    .nmi_taken_i(nmi_taken), .debug_mode_i(debug_mode),
    .save_cause_i(save_cause), .cause_irq_i(cause_irq),
    .cause_code_i(cause_code), .mepc_next_i(mepc_next),
    .cfg_we_i(cfg_we), .cfg_addr_i(cfg_addr), .cfg_wdata_i(cfg_wdata),
    .match_o(match), .mismatch_o(mismatch), .found_exp_o(found_exp), .found_act_o(found_act)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic trap_check_pkg::class_vec_t onehot(input int c);
    trap_check_pkg::class_vec_t v;
    v = '0;
    v[c] = 1'b1;
    return v;
  endfunction

  // Bit 0 has the highest priority, so it is applied last
  function automatic trap_check_pkg::class_vec_t priority_class(
    input trap_check_pkg::class_vec_t flags);
    trap_check_pkg::class_vec_t hit;
    hit = '0;
    for (int c = `TC_NUM_CLASS - 1; c >= 0; c--) begin
      if (flags[c]) begin
        hit = onehot(c);
      end
    end
    return hit;
  endfunction

  function automatic trap_check_pkg::cause_code_t cause_of(input int c);
    trap_check_pkg::cause_code_t code;
    case (c)
      0:       code = `TC_CAUSE_INSTR_FAULT;
      1:       code = `TC_CAUSE_INSTR_BUS_FAULT;
      2:       code = `TC_CAUSE_ILLEGAL;
      3:       code = `TC_CAUSE_ECALL_M;
      default: code = `TC_CAUSE_BREAKPOINT;
    endcase
    return code;
  endfunction

  function automatic trap_check_pkg::class_vec_t decode_cause(
    input trap_check_pkg::cause_code_t code);
    trap_check_pkg::class_vec_t hit;
    hit = '0;
    for (int c = 0; c < `TC_NUM_CLASS; c++) begin
      if (code == cause_of(c)) begin
        hit = onehot(c);
      end
    end
    return hit;
  endfunction

  // One clock edge of the model on the inputs that the DUT samples at that edge
  task automatic model_step();
    trap_check_pkg::class_vec_t hit_exp, hit_act, both;
    logic qual;
    both = m_found_exp & m_found_act;
    qual = wb_valid && !irq_ack && !(debug_pending && debug_allowed) && !nmi_taken &&
           !debug_mode;
    hit_exp = qual ? priority_class({wb_ebreak, wb_ecall, wb_illegal, wb_bus_err, wb_mpu_err})
                   : '0;
    hit_act = (save_cause && !cause_irq) ? decode_cause(cause_code) : '0;
    if (m_clear) begin
      m_found_exp = '0;
      m_found_act = '0;
      m_match     = '0;
      m_mismatch  = '0;
    end else begin
      for (int c = 0; c < `TC_NUM_CLASS; c++) begin
        // Verdict uses the log contents from before this edge
        if (both[c] && !m_match[c] && !m_mismatch[c]) begin
          if (m_exp_pc[c] == m_act_pc[c]) begin
            m_match[c] = 1'b1;
          end else begin
            m_mismatch[c] = 1'b1;
          end
        end
        if (hit_exp[c] && m_en[c] && !m_found_exp[c]) begin
          m_found_exp[c] = 1'b1;
          m_exp_pc[c]    = wb_pc;
        end
        if (hit_act[c] && m_en[c] && !m_found_act[c]) begin
          m_found_act[c] = 1'b1;
          m_act_pc[c]    = mepc_next;
        end
      end
    end
    if (cfg_we && cfg_addr == `TC_CFG_ENABLE) begin
      m_en = cfg_wdata;
    end
    m_clear = cfg_we && (cfg_addr == `TC_CFG_CLEAR);
  endtask

  always @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      m_clear     = 1'b0;
      m_en        = '1;
      m_found_exp = '0;
      m_found_act = '0;
      m_match     = '0;
      m_mismatch  = '0;
      for (int c = 0; c < `TC_NUM_CLASS; c++) begin
        m_exp_pc[c] = '0;
        m_act_pc[c] = '0;
      end
    end else begin
      model_step();
    end
  end

  task automatic check_value(input string name, input trap_check_pkg::class_vec_t expected,
                             input trap_check_pkg::class_vec_t actual);
    if (expected !== actual) begin
      errors++;
      $display("ERR %s expected %h got %h at %0t ns", name, expected, actual, $time);
    end
  endtask

  // Outputs settle after the rising edge, so they are compared on the falling one
  always @(negedge clk) begin
    if (rst_ni) begin
      check_value("found_exp_o", m_found_exp, found_exp);
      check_value("found_act_o", m_found_act, found_act);
      check_value("match_o", m_match, match);
      check_value("mismatch_o", m_mismatch, mismatch);
    end
  end

  task automatic check_outputs(input trap_check_pkg::class_vec_t fe, fa, mt, mm);
    @(negedge clk);
    check_value("found_exp_o", fe, found_exp);
    check_value("found_act_o", fa, found_act);
    check_value("match_o", mt, match);
    check_value("mismatch_o", mm, mismatch);
  endtask

  // Every event input falls back to idle unless the caller drives it again
  task automatic next_cycle();
    @(posedge clk);
    {wb_valid, wb_mpu_err, wb_bus_err, wb_illegal, wb_ecall, wb_ebreak} <= '0;
    {irq_ack, debug_pending, debug_allowed, nmi_taken, debug_mode} <= '0;
    {save_cause, cause_irq, cfg_we} <= '0;
  endtask

  task automatic settle(input int n);
    repeat (n) next_cycle();
  endtask

  // Blocker bits are irq_ack, debug_pending, debug_allowed, nmi_taken, debug_mode
  task automatic retire(input trap_check_pkg::pc_t pc, input trap_check_pkg::class_vec_t flags,
                        input logic [4:0] block);
    next_cycle();
    wb_valid <= 1'b1;
    wb_pc    <= pc;
    {wb_ebreak, wb_ecall, wb_illegal, wb_bus_err, wb_mpu_err} <= flags;
    {debug_mode, nmi_taken, debug_allowed, debug_pending, irq_ack} <= block;
  endtask

  task automatic save(input logic irq, input int c, input trap_check_pkg::pc_t mepc);
    next_cycle();
    save_cause <= 1'b1;
    cause_irq  <= irq;
    cause_code <= cause_of(c);
    mepc_next  <= mepc;
  endtask

  task automatic cfg_write(input trap_check_pkg::cfg_addr_t addr,
                           input trap_check_pkg::class_vec_t data);
    next_cycle();
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
  endtask

  task automatic clear_logs();
    cfg_write(`TC_CFG_CLEAR, '0);
    settle(2);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_match_stream();
    clear_logs();
    for (int i = 0; i < STREAM_LEN; i++) begin
      retire($urandom & 32'hffff_fffe, onehot(int'($urandom_range(0, 4))), '0);
    end
    settle(2);
    for (int c = 0; c < `TC_NUM_CLASS; c++) begin
      if (m_found_exp[c]) begin
        save(1'b0, c, m_exp_pc[c]);
      end
    end
    settle(3);
    check_outputs(m_found_exp, m_found_exp, m_found_exp, '0);
  endtask

  task automatic test_corrupt();
    int k;
    k = int'($urandom_range(0, 4));
    clear_logs();
    for (int c = 0; c < `TC_NUM_CLASS; c++) begin
      retire($urandom & 32'hffff_fffe, onehot(c), '0);
    end
    settle(2);
    for (int c = 0; c < `TC_NUM_CLASS; c++) begin
      save(1'b0, c, (c == k) ? (m_exp_pc[c] ^ ($urandom | 32'h1)) : m_exp_pc[c]);
    end
    settle(3);
    check_outputs('1, '1, ~onehot(k), onehot(k));
  endtask

  task automatic test_priority();
    clear_logs();
    for (int i = 0; i < STREAM_LEN; i++) begin
      retire($urandom, 5'($urandom), '0);
    end
    settle(2);
    check_outputs(m_found_exp, '0, '0, '0);
  endtask

  task automatic test_blocked();
    logic [4:0] block;
    clear_logs();
    for (int i = 0; i < STREAM_LEN / 2; i++) begin
      case ($urandom_range(0, 3))
        0:       block = 5'b00001;
        1:       block = 5'b00110;
        2:       block = 5'b01000;
        default: block = 5'b10000;
      endcase
      retire($urandom, 5'($urandom_range(1, 31)), block);
      save(1'b1, int'($urandom_range(0, 4)), $urandom);
    end
    settle(2);
    check_outputs('0, '0, '0, '0);
  endtask

  task automatic test_mask_clear();
    trap_check_pkg::class_vec_t mask;
    trap_check_pkg::pc_t        first_pc [`TC_NUM_CLASS];
    mask = 5'($urandom_range(1, 30));
    clear_logs();
    cfg_write(`TC_CFG_ENABLE, mask);
    // The second retire lands before the save that completes the class
    for (int c = 0; c < `TC_NUM_CLASS; c++) begin
      first_pc[c] = $urandom & 32'hffff_fffc;
      retire(first_pc[c], onehot(c), '0);
      retire(first_pc[c] + 32'h4, onehot(c), '0);
      save(1'b0, c, first_pc[c]);
      save(1'b0, c, first_pc[c] + 32'h8);
    end
    settle(3);
    check_outputs(mask, mask, mask, '0);
    clear_logs();
    check_outputs('0, '0, '0, '0);
    cfg_write(`TC_CFG_ENABLE, '1);
    // Saves go first here so that a second mepc would be seen by the verdict
    for (int c = 0; c < `TC_NUM_CLASS; c++) begin
      first_pc[c] = $urandom & 32'hffff_fffc;
      save(1'b0, c, first_pc[c]);
      save(1'b0, c, first_pc[c] + 32'h8);
      retire(first_pc[c], onehot(c), '0);
      retire(first_pc[c] + 32'h4, onehot(c), '0);
    end
    settle(3);
    check_outputs('1, '1, '1, '0);
  endtask

  initial begin
    void'($urandom(32'h7f24_32f9));
    clk = 1'b0;
    rst_ni = 1'b0;
    {wb_valid, wb_mpu_err, wb_bus_err, wb_illegal, wb_ecall, wb_ebreak} = '0;
    {irq_ack, debug_pending, debug_allowed, nmi_taken, debug_mode} = '0;
    {save_cause, cause_irq, cfg_we} = '0;
    wb_pc = '0;
    mepc_next = '0;
    cause_code = '0;
    cfg_addr = '0;
    cfg_wdata = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_ni <= 1'b1;
    settle(2);
    test_match_stream();
    test_corrupt();
    test_priority();
    test_blocked();
    test_mask_clear();
    settle(2);
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the stream lengths above
  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/trap_check_checker.sv */
////////////////////
// Trap check assertions
// Watches the result flags of the top level
////////////////////

`timescale 1ns/1ns
`default_nettype none

module trap_check_checker (
  input wire logic                       clk,
  input wire logic                       rst_ni,
  input wire logic                       wb_valid_i,
  input wire logic                       save_cause_i,
  input wire trap_check_pkg::class_vec_t match_i,
  input wire trap_check_pkg::class_vec_t mismatch_i,
  input wire trap_check_pkg::class_vec_t found_exp_i,
  input wire trap_check_pkg::class_vec_t found_act_i
);

  logic event_seen_q;

  // Set by the first edge that carries a retire or a cause save
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      event_seen_q <= 1'b0;
    end else if (wb_valid_i || save_cause_i) begin
      event_seen_q <= 1'b1;
    end
  end

  // A class gets one verdict, never both
  a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_ni)
    (match_i & mismatch_i) == '0)
    else $error("match and mismatch are both set for one class");

  // A verdict needs both logs filled for its class
  a_flag_needs_found: assert property (@(posedge clk) disable iff (!rst_ni)
    ((match_i | mismatch_i) & ~(found_exp_i & found_act_i)) == '0)
    else $error("a compare flag is set without both found bits");

  a_quiet_after_reset: assert property (@(posedge clk) disable iff (!rst_ni)
    !event_seen_q |-> (match_i | mismatch_i | found_exp_i | found_act_i) == '0)
    else $error("an output went high before any event was seen");

endmodule

bind trap_check_top trap_check_checker u_checker (
  .clk         (clk),
  .rst_ni      (rst_ni),
  .wb_valid_i  (wb_valid_i),
  .save_cause_i(save_cause_i),
  .match_i     (match_o),
  .mismatch_i  (mismatch_o),
  .found_exp_i (found_exp_o),
  .found_act_i (found_act_o)
);

`default_nettype wire

/* rtl/trap_check_top.sv */
////////////////////
// Trap check top level
// Connects the configuration block, both PC logs and the comparator
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "trap_check_consts.svh"

module trap_check_top (
  input  wire logic                        clk,
  input  wire logic                        rst_ni,
  // Write-back stage
  input  wire logic                        wb_valid_i,
  input  wire trap_check_pkg::pc_t         wb_pc_i,
  input  wire logic                        wb_mpu_err_i,
  input  wire logic                        wb_bus_err_i,
  input  wire logic                        wb_illegal_i,
  input  wire logic                        wb_ecall_i,
  input  wire logic                        wb_ebreak_i,
  input  wire logic                        irq_ack_i,
  input  wire logic                        debug_pending_i,
  input  wire logic                        debug_allowed_i,
  input  wire logic                        nmi_taken_i,
  input  wire logic                        debug_mode_i,
  // Cause save
  input  wire logic                        save_cause_i,
  input  wire logic                        cause_irq_i,
  input  wire trap_check_pkg::cause_code_t cause_code_i,
  input  wire trap_check_pkg::pc_t         mepc_next_i,
  // Configuration write
  input  wire logic                        cfg_we_i,
  input  wire trap_check_pkg::cfg_addr_t   cfg_addr_i,
  input  wire trap_check_pkg::class_vec_t  cfg_wdata_i,
  // Results
  output trap_check_pkg::class_vec_t       match_o,
  output trap_check_pkg::class_vec_t       mismatch_o,
  output trap_check_pkg::class_vec_t       found_exp_o,
  output trap_check_pkg::class_vec_t       found_act_o
);

  trap_check_pkg::class_vec_t              class_en;
  logic                                    clear;
  trap_check_pkg::pc_t [`TC_NUM_CLASS-1:0] exp_pc;
  trap_check_pkg::pc_t [`TC_NUM_CLASS-1:0] act_pc;

  trap_check_cfg u_cfg (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .cfg_we_i   (cfg_we_i),
    .cfg_addr_i (cfg_addr_i),
    .cfg_wdata_i(cfg_wdata_i),
    .class_en_o (class_en),
    .clear_o    (clear)
  );

  // PCs of the instructions that should have trapped
  expected_pc_log u_exp_log (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .wb_valid_i     (wb_valid_i),
    .wb_pc_i        (wb_pc_i),
    .wb_mpu_err_i   (wb_mpu_err_i),
    .wb_bus_err_i   (wb_bus_err_i),
    .wb_illegal_i   (wb_illegal_i),
    .wb_ecall_i     (wb_ecall_i),
    .wb_ebreak_i    (wb_ebreak_i),
    .irq_ack_i      (irq_ack_i),
    .debug_pending_i(debug_pending_i),
    .debug_allowed_i(debug_allowed_i),
    .nmi_taken_i    (nmi_taken_i),
    .debug_mode_i   (debug_mode_i),
    .class_en_i     (class_en),
    .clear_i        (clear),
    .found_o        (found_exp_o),
    .exp_pc_o       (exp_pc)
  );

  // mepc values the core actually saved
  actual_mepc_log u_act_log (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .save_cause_i(save_cause_i),
    .cause_irq_i (cause_irq_i),
    .cause_code_i(cause_code_i),
    .mepc_next_i (mepc_next_i),
    .class_en_i  (class_en),
    .clear_i     (clear),
    .found_o     (found_act_o),
    .act_pc_o    (act_pc)
  );

  mepc_compare u_compare (
    .clk        (clk),
    .rst_ni     (rst_ni),
    .clear_i    (clear),
    .found_exp_i(found_exp_o),
    .found_act_i(found_act_o),
    .exp_pc_i   (exp_pc),
    .act_pc_i   (act_pc),
    .match_o    (match_o),
    .mismatch_o (mismatch_o)
  );

endmodule

`default_nettype wire

/* rtl/mepc_compare.sv */
////////////////////
// mepc comparator
// Sets a sticky match or mismatch flag per class once both logs are filled
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "trap_check_consts.svh"

module mepc_compare (
  input  wire logic                                clk,
  input  wire logic                                rst_ni,
  input  wire logic                                clear_i,
  input  wire trap_check_pkg::class_vec_t          found_exp_i,
  input  wire trap_check_pkg::class_vec_t          found_act_i,
  input  wire trap_check_pkg::pc_t [`TC_NUM_CLASS-1:0] exp_pc_i,
  input  wire trap_check_pkg::pc_t [`TC_NUM_CLASS-1:0] act_pc_i,
  output trap_check_pkg::class_vec_t               match_o,
  output trap_check_pkg::class_vec_t               mismatch_o
);

  trap_check_pkg::class_vec_t both_found;
  trap_check_pkg::class_vec_t pc_equal;
  trap_check_pkg::class_vec_t decided;
  trap_check_pkg::class_vec_t match_q;
  trap_check_pkg::class_vec_t mismatch_q;

  // A class is ready for a verdict once the expected PC and the saved
  // mepc have both been logged
  assign both_found = found_exp_i & found_act_i;
  assign decided    = match_q | mismatch_q;

  always_comb begin
    for (int c = 0; c < `TC_NUM_CLASS; c++) begin
      pc_equal[c] = (exp_pc_i[c] == act_pc_i[c]);
    end
  end

  // The verdict is taken once and then frozen
  // Exactly one of the two flags is set, so they never overlap
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      match_q    <= '0;
      mismatch_q <= '0;
    end else if (clear_i) begin
      match_q    <= '0;
      mismatch_q <= '0;
    end else begin
      match_q    <= match_q | (both_found & ~decided & pc_equal);
      mismatch_q <= mismatch_q | (both_found & ~decided & ~pc_equal);
    end
  end

  assign match_o    = match_q;
  assign mismatch_o = mismatch_q;

endmodule

`default_nettype wire

/* rtl/actual_mepc_log.sv */
////////////////////
// Actual mepc log
// Decodes saved exception causes and keeps the first mepc per class
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "trap_check_consts.svh"

module actual_mepc_log (
  input  wire logic                                clk,
  input  wire logic                                rst_ni,
  // Cause save from the controller
  input  wire logic                                save_cause_i,
  input  wire logic                                cause_irq_i,
  input  wire trap_check_pkg::cause_code_t         cause_code_i,
  input  wire trap_check_pkg::pc_t                 mepc_next_i,
  // Configuration
  input  wire trap_check_pkg::class_vec_t          class_en_i,
  input  wire logic                                clear_i,
  // Log contents
  output trap_check_pkg::class_vec_t               found_o,
  output trap_check_pkg::pc_t [`TC_NUM_CLASS-1:0]  act_pc_o
);

  logic                                     save_exc;
  trap_check_pkg::class_vec_t               class_hit;
  trap_check_pkg::class_vec_t               capture;
  trap_check_pkg::class_vec_t               found_q;
  trap_check_pkg::pc_t [`TC_NUM_CLASS-1:0]  mepc_q;

  // Saves made for interrupts are not exceptions and are skipped
  assign save_exc = save_cause_i && !cause_irq_i;

  // Map the cause code onto the same class bits as the expected log
  always_comb begin
    class_hit = '0;
    if (save_exc) begin
      case (cause_code_i)
        `TC_CAUSE_INSTR_FAULT:     class_hit[0] = 1'b1;
        `TC_CAUSE_INSTR_BUS_FAULT: class_hit[1] = 1'b1;
        `TC_CAUSE_ILLEGAL:         class_hit[2] = 1'b1;
        `TC_CAUSE_ECALL_M:         class_hit[3] = 1'b1;
        `TC_CAUSE_BREAKPOINT:      class_hit[4] = 1'b1;
        // Any other exception code is of no interest here
        default:                   class_hit = '0;
      endcase
    end
  end

  assign capture = class_hit & class_en_i & ~found_q;

  // Found bits stick until the next clear
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      found_q <= '0;
    end else if (clear_i) begin
      found_q <= '0;
    end else begin
      found_q <= found_q | capture;
    end
  end

  // Saved mepc values, each valid once its found bit is set
  always_ff @(posedge clk) begin
    for (int c = 0; c < `TC_NUM_CLASS; c++) begin
      if (clear_i) begin
        mepc_q[c] <= '0;
      end else if (capture[c]) begin
        mepc_q[c] <= mepc_next_i;
      end
    end
  end

  assign found_o  = found_q;
  assign act_pc_o = mepc_q;

endmodule

`default_nettype wire

/* rtl/expected_pc_log.sv */
////////////////////
// Expected PC log
// Classifies retiring instructions by exception priority and keeps the
// PC of the first one seen for each class
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "trap_check_consts.svh"

module expected_pc_log (
  input  wire logic                                        clk,
  input  wire logic                                        rst_ni,
  // Write-back stage
  input  wire logic                                        wb_valid_i,
  input  wire trap_check_pkg::pc_t                         wb_pc_i,
  input  wire logic                                        wb_mpu_err_i,
  input  wire logic                                        wb_bus_err_i,
  input  wire logic                                        wb_illegal_i,
  input  wire logic                                        wb_ecall_i,
  input  wire logic                                        wb_ebreak_i,
  // Conditions under which the instruction does not trap
  input  wire logic                                        irq_ack_i,
  input  wire logic                                        debug_pending_i,
  input  wire logic                                        debug_allowed_i,
  input  wire logic                                        nmi_taken_i,
  input  wire logic                                        debug_mode_i,
  // Configuration
  input  wire trap_check_pkg::class_vec_t                  class_en_i,
  input  wire logic                                        clear_i,
  // Log contents
  output trap_check_pkg::class_vec_t                       found_o,
  output trap_check_pkg::pc_t [`TC_NUM_CLASS-1:0]          exp_pc_o
);

  logic                                     qualify;
  trap_check_pkg::class_vec_t               class_hit;
  trap_check_pkg::class_vec_t               capture;
  trap_check_pkg::class_vec_t               found_q;
  trap_check_pkg::pc_t [`TC_NUM_CLASS-1:0]  pc_q;

  ////////////////////
  // Qualification
  ////////////////////

  // An interrupt, a debug entry or an NMI takes the instruction away
  // before it can raise its own exception, and nothing traps in debug mode
  assign qualify = wb_valid_i && !irq_ack_i && !(debug_pending_i && debug_allowed_i) &&
                   !nmi_taken_i && !debug_mode_i;

  // Only the highest priority exception of an instruction is taken
  always_comb begin
    class_hit = '0;
    if (qualify) begin
      if (wb_mpu_err_i) begin
        class_hit[0] = 1'b1;
      end else if (wb_bus_err_i) begin
        class_hit[1] = 1'b1;
      end else if (wb_illegal_i) begin
        class_hit[2] = 1'b1;
      end else if (wb_ecall_i) begin
        class_hit[3] = 1'b1;
      end else if (wb_ebreak_i) begin
        class_hit[4] = 1'b1;
      end
    end
  end

  ////////////////////
  // Capture
  ////////////////////

  // First occurrence only, and only for classes being checked
  assign capture = class_hit & class_en_i & ~found_q;

  // Clear wins over a capture in the same cycle
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      found_q <= '0;
    end else if (clear_i) begin
      found_q <= '0;
    end else begin
      found_q <= found_q | capture;
    end
  end

  // The stored PC is only looked at once its found bit is set
  always_ff @(posedge clk) begin
    for (int c = 0; c < `TC_NUM_CLASS; c++) begin
      if (clear_i) begin
        pc_q[c] <= '0;
      end else if (capture[c]) begin
        pc_q[c] <= wb_pc_i;
      end
    end
  end

  assign found_o  = found_q;
  assign exp_pc_o = pc_q;

endmodule

`default_nettype wire

/* rtl/trap_check_cfg.sv */
////////////////////
// Trap check configuration
// Holds the class enable mask and issues a one-cycle clear pulse
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "trap_check_consts.svh"

module trap_check_cfg (
  input  wire logic                      clk,
  input  wire logic                      rst_ni,
  input  wire logic                      cfg_we_i,
  input  wire trap_check_pkg::cfg_addr_t cfg_addr_i,
  input  wire trap_check_pkg::class_vec_t cfg_wdata_i,
  output trap_check_pkg::class_vec_t     class_en_o,
  output logic                           clear_o
);

  trap_check_pkg::class_vec_t class_en_q;
  logic                       clear_q;

  // Write strobes decoded from the address
  logic wr_enable;
  logic wr_clear;

  assign wr_enable = cfg_we_i && (cfg_addr_i == `TC_CFG_ENABLE);
  assign wr_clear  = cfg_we_i && (cfg_addr_i == `TC_CFG_CLEAR);

  // Every class is checked until software masks it off
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      class_en_q <= {`TC_NUM_CLASS{1'b1}};
    end else if (wr_enable) begin
      class_en_q <= cfg_wdata_i;
    end
  end

  // The clear command is a pulse, the written data is ignored
  // It falls again on the next edge unless another clear write follows
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      clear_q <= 1'b0;
    end else begin
      clear_q <= wr_clear;
    end
  end

  assign class_en_o = class_en_q;
  assign clear_o    = clear_q;

endmodule

`default_nettype wire

/* rtl/trap_check_pkg.sv */
////////////////////
// Trap check types
// Vector types shared by the configuration, the logs and the comparator
////////////////////

`default_nettype none

`include "trap_check_consts.svh"

package trap_check_pkg;

  // A PC as seen in write-back, or the mepc value about to be saved
  typedef logic [`TC_XLEN-1:0] pc_t;

  // Exception code part of the cause being saved
  typedef logic [`TC_CAUSE_W-1:0] cause_code_t;

  // One bit per exception class
  // Bit 0 mpu fault, bit 1 instruction bus fault, bit 2 illegal,
  // bit 3 ecall and bit 4 ebreak
  typedef logic [`TC_NUM_CLASS-1:0] class_vec_t;

  // Address of a configuration register
  typedef logic [`TC_CFG_ADDR_W-1:0] cfg_addr_t;

endpackage

`default_nettype wire

/* rtl/trap_check_consts.svh */
////////////////////
// Trap check constants
// Widths, class count, exception cause codes and configuration addresses
////////////////////

`ifndef TRAP_CHECK_CONSTS_SVH
`define TRAP_CHECK_CONSTS_SVH

// Width of a PC or mepc value
`define TC_XLEN       32
// One class each for mpu fault, bus fault, illegal, ecall and ebreak
`define TC_NUM_CLASS  5
// Exception code field of mcause
`define TC_CAUSE_W    11
`define TC_CFG_ADDR_W 1

// Configuration register map
`define TC_CFG_ENABLE 1'b0
`define TC_CFG_CLEAR  1'b1

// Exception codes saved with a synchronous trap
`define TC_CAUSE_INSTR_FAULT     11'd1
`define TC_CAUSE_ILLEGAL         11'd2
`define TC_CAUSE_BREAKPOINT      11'd3
`define TC_CAUSE_ECALL_M         11'd11
`define TC_CAUSE_INSTR_BUS_FAULT 11'd24

`endif
